// File: include/decode_consts.svh
// decode stage constants
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// machine word width in bits
`define WORD_W 32

// register file depth
`define REG_N 32

// bits needed to name one register
`define REG_W 5

// jal writes its return address here
`define LINK_REG 5'd31

// halt opcode, all ones
`define OP_HALT 6'b111111

`endif

// File: logic/cpu_types_pkg.sv
// instruction set types
`include "decode_consts.svh"

package cpu_types_pkg;

	// basic data and register index
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_W-1:0] regbits_t;

	// primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		ADDIU = 6'h09,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = `OP_HALT
	} opcode_t;

	// r-type function codes, bits 5:0
	typedef enum logic [5:0] {
		SLL = 6'h00,
		JR  = 6'h08,
		ADD = 6'h20,
		SUB = 6'h22,
		AND = 6'h24,
		OR  = 6'h25,
		SLT = 6'h2a
	} funct_t;

	// alu operations seen by execute
	typedef enum logic [3:0] {
		ALU_SLL = 4'h0,
		ALU_ADD = 4'h1,
		ALU_SUB = 4'h2,
		ALU_AND = 4'h3,
		ALU_OR  = 4'h4,
		ALU_SLT = 4'h5
	} aluop_t;

	// immediate extension modes
	typedef enum logic [1:0] {
		ZERO  = 2'd0,
		SIGN  = 2'd1,
		UPPER = 2'd2
	} ext_t;

endpackage

// File: logic/pipe_types_pkg.sv
// pipeline packet types
`include "decode_consts.svh"

package pipe_types_pkg;

	// fetch to decode, instruction plus pc+4
	typedef struct packed {
		logic [`WORD_W-1:0] instr;
		cpu_types_pkg::word_t npc;
	} fetch_t;

	// writeback port into the register file
	typedef struct packed {
		logic wen;
		cpu_types_pkg::regbits_t wsel;
		cpu_types_pkg::word_t wdat;
	} writeback_t;

	// jump select, none / j-type target / jr register
	typedef enum logic [1:0] {
		JS_NONE   = 2'd0,
		JS_TARGET = 2'd1,
		JS_REG    = 2'd2
	} jumpsel_t;

	// control unit output bundle
	typedef struct packed {
		cpu_types_pkg::aluop_t alu_op;
		logic alu_src;
		cpu_types_pkg::ext_t ext_op;
		logic dren;
		logic dwen;
		logic beq;
		logic bne;
		jumpsel_t jump_sel;
		logic reg_wen;
		logic reg_dst;
		logic jal;
		logic mem_to_reg;
		logic halt;
	} ctrl_t;

	// decode to execute packet
	typedef struct packed {
		cpu_types_pkg::regbits_t rs;
		cpu_types_pkg::regbits_t rt;
		cpu_types_pkg::regbits_t rd;
		cpu_types_pkg::regbits_t rw;
		ctrl_t ctrl;
		cpu_types_pkg::word_t port_a;
		cpu_types_pkg::word_t port_b;
		cpu_types_pkg::word_t imm_ext;
		cpu_types_pkg::word_t jump_addr;
		cpu_types_pkg::word_t npc;
		logic [`WORD_W-1:0] instr;
	} decode_t;

endpackage

// File: logic/control_unit.sv
// main control decoder
module control_unit (
	input cpu_types_pkg::opcode_t opcode,
	input cpu_types_pkg::funct_t funct,
	output pipe_types_pkg::ctrl_t ctrl
);

	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	always_comb begin
		// unknown encodings fall through as a no-op
		ctrl = '0;
		case (opcode)
			RTYPE: begin
				// register-register ops write rd
				case (funct)
					ADD: begin
						ctrl.alu_op = ALU_ADD;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					SUB: begin
						ctrl.alu_op = ALU_SUB;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					AND: begin
						ctrl.alu_op = ALU_AND;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					OR: begin
						ctrl.alu_op = ALU_OR;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					SLT: begin
						ctrl.alu_op = ALU_SLT;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					SLL: begin
						// shift amount comes from the shamt field downstream
						ctrl.alu_op = ALU_SLL;
						ctrl.reg_wen = 1'b1;
						ctrl.reg_dst = 1'b1;
					end
					// jump through rs, no register write
					JR: ctrl.jump_sel = JS_REG;
					default: ctrl = '0;
				endcase
			end
			ADDI, ADDIU: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = SIGN;
				ctrl.reg_wen = 1'b1;
			end
			ANDI: begin
				// logical immediates are zero extended
				ctrl.alu_op = ALU_AND;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = ZERO;
				ctrl.reg_wen = 1'b1;
			end
			ORI: begin
				ctrl.alu_op = ALU_OR;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = ZERO;
				ctrl.reg_wen = 1'b1;
			end
			LUI: begin
				// upper immediate or'd with rs, which is $0 in a normal encoding
				ctrl.alu_op = ALU_OR;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = UPPER;
				ctrl.reg_wen = 1'b1;
			end
			LW: begin
				// base + offset, result from memory
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = SIGN;
				ctrl.dren = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			SW: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src = 1'b1;
				ctrl.ext_op = SIGN;
				ctrl.dwen = 1'b1;
			end
			BEQ: begin
				// compare by subtract, offset sign extended
				ctrl.alu_op = ALU_SUB;
				ctrl.ext_op = SIGN;
				ctrl.beq = 1'b1;
			end
			BNE: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.ext_op = SIGN;
				ctrl.bne = 1'b1;
			end
			J: ctrl.jump_sel = JS_TARGET;
			JAL: begin
				// link into r31
				ctrl.jump_sel = JS_TARGET;
				ctrl.reg_wen = 1'b1;
				ctrl.jal = 1'b1;
			end
			HALT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// memory stage must never see a load and a store at once
	always_comb begin
		assert (!(ctrl.dren && ctrl.dwen))
			else $error("control_unit: dren and dwen both set, opcode %h", opcode);
	end

endmodule

// File: logic/register_file.sv
// register file
`include "decode_consts.svh"

module register_file (
	input logic CLK,
	input logic nRST,
	input logic wen,
	input cpu_types_pkg::regbits_t wsel,
	input cpu_types_pkg::regbits_t rsel1,
	input cpu_types_pkg::regbits_t rsel2,
	input cpu_types_pkg::word_t wdat,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2
);

	import cpu_types_pkg::*;

	// storage, r0 included but never written
	word_t regs [`REG_N];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			regs <= '{default: '0};
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// combinational reads, no write bypass
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	// r0 stays zero through reset and any writeback aimed at it
	assert property (@(posedge CLK) disable iff (!nRST)
		((rsel1 == '0) |-> (rdat1 == '0)) and ((rsel2 == '0) |-> (rdat2 == '0)))
		else $error("register_file: r0 read back nonzero");

endmodule

// File: logic/decode_stage.sv
// decode pipeline stage
`include "decode_consts.svh"

module decode_stage (
	input logic CLK,
	input logic nRST,
	input logic fetch_valid,
	output logic fetch_ready,
	input pipe_types_pkg::fetch_t fetch,
	output logic dec_valid,
	input logic dec_ready,
	output pipe_types_pkg::decode_t dec,
	input logic flush,
	output logic halted,
	output cpu_types_pkg::opcode_t opcode,
	output cpu_types_pkg::funct_t funct,
	input pipe_types_pkg::ctrl_t ctrl,
	output cpu_types_pkg::regbits_t rsel1,
	output cpu_types_pkg::regbits_t rsel2,
	input cpu_types_pkg::word_t rdat1,
	input cpu_types_pkg::word_t rdat2
);

	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	// run until a halt is accepted, then stay put until reset
	typedef enum logic {
		RUN,
		HALTED
	} state_t;

	state_t state;

	// instruction fields
	regbits_t rs;
	regbits_t rt;
	regbits_t rd;
	logic [15:0] imm;
	word_t imm_ext;
	regbits_t rw;
	decode_t next_dec;
	logic accept;

	always_comb begin
		opcode = opcode_t'(fetch.instr[31:26]);
		funct = funct_t'(fetch.instr[5:0]);
		rs = fetch.instr[25:21];
		rt = fetch.instr[20:16];
		rd = fetch.instr[15:11];
		imm = fetch.instr[15:0];
	end

	// operand reads by rs and rt
	assign rsel1 = rs;
	assign rsel2 = rt;

	// immediate extension picked by the control unit
	always_comb begin
		case (ctrl.ext_op)
			SIGN: imm_ext = {{16{imm[15]}}, imm};
			UPPER: imm_ext = {imm, 16'h0000};
			default: imm_ext = {16'h0000, imm};
		endcase
	end

	// destination, r0 when nothing gets written
	always_comb begin
		if (!ctrl.reg_wen)
			rw = '0;
		else if (ctrl.jal)
			rw = `LINK_REG;
		else if (ctrl.reg_dst)
			rw = rd;
		else
			rw = rt;
	end

	// packet about to be latched
	always_comb begin
		next_dec.rs = rs;
		next_dec.rt = rt;
		next_dec.rd = rd;
		next_dec.rw = rw;
		next_dec.ctrl = ctrl;
		next_dec.port_a = rdat1;
		next_dec.port_b = rdat2;
		next_dec.imm_ext = imm_ext;
		// pc region bits, 26-bit target, word aligned
		next_dec.jump_addr = {fetch.npc[31:28], fetch.instr[25:0], 2'b00};
		next_dec.npc = fetch.npc;
		next_dec.instr = fetch.instr;
	end

	// take a new packet only when running, output free or draining, no flush
	assign fetch_ready = (state == RUN) && (!dec_valid || dec_ready) && !flush;
	assign accept = fetch_valid && fetch_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dec_valid <= 1'b0;
		end else if (flush) begin
			// drop the held packet
			dec_valid <= 1'b0;
		end else if (accept) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

	// payload only moves on accept
	always_ff @(posedge CLK) begin
		if (accept)
			dec <= next_dec;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= RUN;
		end else begin
			case (state)
				// the halt packet itself is latched on this same edge
				RUN: if (accept && ctrl.halt) state <= HALTED;
				HALTED: state <= HALTED;
				default: state <= RUN;
			endcase
		end
	end

	assign halted = (state == HALTED);

	// a stalled packet holds still for the execute stage
	assert property (@(posedge CLK) disable iff (!nRST)
		(dec_valid && !dec_ready && !flush) |=> (dec_valid && $stable(dec)))
		else $error("decode_stage: dec changed under back-pressure");

endmodule

// File: logic/decode_top.sv
// decode stage top level
module decode_top (
	input logic CLK,
	input logic nRST,
	input logic fetch_valid,
	output logic fetch_ready,
	input pipe_types_pkg::fetch_t fetch,
	output logic dec_valid,
	input logic dec_ready,
	output pipe_types_pkg::decode_t dec,
	input pipe_types_pkg::writeback_t writeback,
	input logic flush,
	output logic halted
);

	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	// decode to control unit
	opcode_t opcode;
	funct_t funct;
	ctrl_t ctrl;

	// decode to register file
	regbits_t rsel1;
	regbits_t rsel2;
	word_t rdat1;
	word_t rdat2;

	control_unit control_unit_inst (
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl)
	);

	// writeback goes straight in
	register_file register_file_inst (
		.CLK(CLK),
		.nRST(nRST),
		.wen(writeback.wen),
		.wsel(writeback.wsel),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.wdat(writeback.wdat),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

	decode_stage decode_stage_inst (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch(fetch),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec),
		.flush(flush),
		.halted(halted),
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl),
		.rsel1(rsel1),
		.rsel2(rsel2),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

endmodule

// File: test/decode_tb.sv
// decode stage testbench
`include "decode_consts.svh"

module decode_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	localparam int timeout_cycles = 2000;
	localparam int random_cycles = 3000;

	// random traffic opcodes with two unassigned codes at the end
	localparam logic [5:0] opcode_list [14] = '{
		RTYPE, ADDI, ADDIU, ANDI, ORI, LUI, LW, SW, BEQ, BNE, J, JAL, 6'h1f, 6'h3e
	};
	// r-type function codes plus one unassigned code
	localparam logic [5:0] funct_list [8] = '{ADD, SUB, AND, OR, SLT, SLL, JR, 6'h3f};

	logic CLK;
	logic nRST;
	logic fetch_valid;
	logic fetch_ready;
	fetch_t fetch;
	logic dec_valid;
	logic dec_ready;
	decode_t dec;
	writeback_t writeback;
	logic flush;
	logic halted;

	// reference model state
	integer seed;
	word_t shadow [`REG_N];
	decode_t exp_q [$];
	decode_t held_dec;
	logic held;
	logic model_halted;
	logic offer_pending;
	logic flush_enable;
	logic want_halt;
	logic halt_sent;
	logic halt_left;
	logic timed_out;
	word_t pc;
	int errors;
	int checks;
	int accepted;
	int delivered;
	int dropped;

	decode_top decode_top_inst (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch(fetch),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec),
		.writeback(writeback),
		.flush(flush),
		.halted(halted)
	);

	// 4 ns period
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic logic chance(int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	function automatic logic [31:0] random_instr();
		word_t r;
		logic [3:0] op_idx;
		logic [2:0] fn_idx;
		r = rand_word();
		op_idx = 4'($unsigned($random(seed)) % 14);
		fn_idx = 3'($unsigned($random(seed)) % 8);
		if (opcode_list[op_idx] == RTYPE)
			return {opcode_list[op_idx], r[25:6], funct_list[fn_idx]};
		return {opcode_list[op_idx], r[25:0]};
	endfunction

	// expected control bundle per opcode and function code
	function automatic ctrl_t ctrl_model(logic [5:0] op, logic [5:0] fn);
		ctrl_t c;
		c = '0;
		case (op)
			RTYPE: begin
				c.reg_wen = 1'b1;
				c.reg_dst = 1'b1;
				case (fn)
					ADD: c.alu_op = ALU_ADD;
					SUB: c.alu_op = ALU_SUB;
					AND: c.alu_op = ALU_AND;
					OR: c.alu_op = ALU_OR;
					SLT: c.alu_op = ALU_SLT;
					SLL: c.alu_op = ALU_SLL;
					JR: begin
						c = '0;
						c.jump_sel = JS_REG;
					end
					default: c = '0;
				endcase
			end
			ADDI, ADDIU, LW, SW: begin
				c.alu_op = ALU_ADD;
				c.alu_src = 1'b1;
				c.ext_op = SIGN;
				c.reg_wen = (op != SW);
				c.dren = (op == LW);
				c.mem_to_reg = (op == LW);
				c.dwen = (op == SW);
			end
			ANDI, ORI, LUI: begin
				c.alu_op = (op == ANDI) ? ALU_AND : ALU_OR;
				c.alu_src = 1'b1;
				c.ext_op = (op == LUI) ? UPPER : ZERO;
				c.reg_wen = 1'b1;
			end
			BEQ, BNE: begin
				c.alu_op = ALU_SUB;
				c.ext_op = SIGN;
				c.beq = (op == BEQ);
				c.bne = (op == BNE);
			end
			J: c.jump_sel = JS_TARGET;
			JAL: begin
				c.jump_sel = JS_TARGET;
				c.reg_wen = 1'b1;
				c.jal = 1'b1;
			end
			HALT: c.halt = 1'b1;
			default: c = '0;
		endcase
		return c;
	endfunction

	// packet the stage should latch with operands from the shadow before this edge
	function automatic decode_t expected_packet(fetch_t f);
		decode_t p;
		logic [15:0] imm;
		imm = f.instr[15:0];
		p.instr = f.instr;
		p.npc = f.npc;
		p.rs = f.instr[25:21];
		p.rt = f.instr[20:16];
		p.rd = f.instr[15:11];
		p.ctrl = ctrl_model(f.instr[31:26], f.instr[5:0]);
		case (p.ctrl.ext_op)
			SIGN: p.imm_ext = 32'($signed(imm));
			UPPER: p.imm_ext = word_t'(imm) << 16;
			default: p.imm_ext = word_t'(imm);
		endcase
		if (!p.ctrl.reg_wen)
			p.rw = '0;
		else if (p.ctrl.jal)
			p.rw = `LINK_REG;
		else if (p.ctrl.reg_dst)
			p.rw = p.rd;
		else
			p.rw = p.rt;
		p.port_a = shadow[p.rs];
		p.port_b = shadow[p.rt];
		p.jump_addr = {f.npc[31:28], f.instr[25:0], 2'b00};
		return p;
	endfunction

	task automatic compare_field(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_packet(input decode_t got, input decode_t exp);
		compare_field("dec.rs", 32'(got.rs), 32'(exp.rs));
		compare_field("dec.rt", 32'(got.rt), 32'(exp.rt));
		compare_field("dec.rd", 32'(got.rd), 32'(exp.rd));
		compare_field("dec.rw", 32'(got.rw), 32'(exp.rw));
		compare_field("dec.ctrl", 32'(got.ctrl), 32'(exp.ctrl));
		compare_field("dec.port_a", got.port_a, exp.port_a);
		compare_field("dec.port_b", got.port_b, exp.port_b);
		compare_field("dec.imm_ext", got.imm_ext, exp.imm_ext);
		compare_field("dec.jump_addr", got.jump_addr, exp.jump_addr);
		compare_field("dec.npc", got.npc, exp.npc);
		compare_field("dec.instr", got.instr, exp.instr);
	endtask

	// one clock that checks the last edge, drives inputs and models the next edge
	task automatic run_cycle();
		word_t r;
		logic exp_ready;
		logic accept;
		decode_t front;
		@(negedge CLK);
		if (dec_valid !== (exp_q.size() != 0)) begin
			errors++;
			$display("FAILED dec_valid: got %h expected %h", dec_valid, exp_q.size() != 0);
		end
		if (halted !== model_halted) begin
			errors++;
			$display("FAILED halted: got %h expected %h", halted, model_halted);
		end
		if (held && dec_valid && (dec !== held_dec)) begin
			errors++;
			$display("FAILED dec: held %h changed to %h", held_dec, dec);
		end
		// upstream keeps an offer steady until it is taken
		if (!offer_pending) begin
			r = rand_word();
			fetch_valid = 1'b1;
			if (want_halt && !halt_sent) begin
				fetch.instr = {`OP_HALT, r[25:0]};
				halt_sent = 1'b1;
			end else if (chance(70)) begin
				fetch.instr = random_instr();
			end else begin
				fetch_valid = 1'b0;
			end
			pc = pc + 32'd4;
			fetch.npc = pc;
		end
		r = rand_word();
		dec_ready = chance(60);
		writeback.wen = chance(40);
		writeback.wsel = r[4:0];
		writeback.wdat = rand_word();
		flush = flush_enable && chance(3);
		#1;
		exp_ready = !model_halted && ((exp_q.size() == 0) || dec_ready) && !flush;
		if (fetch_ready !== exp_ready) begin
			errors++;
			$display("FAILED fetch_ready: got %h expected %h", fetch_ready, exp_ready);
		end
		if (dec_valid && !dec_ready && fetch_ready) begin
			errors++;
			$display("FAILED fetch_ready: got %h expected %h under back-pressure",
				fetch_ready, 1'b0);
		end
		accept = fetch_valid && exp_ready;
		// output side of the coming edge
		if (dec_valid && dec_ready) begin
			delivered++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: a packet came out that was never accepted");
			end else begin
				front = exp_q.pop_front();
				compare_packet(dec, front);
				if (front.ctrl.halt)
					halt_left = 1'b1;
			end
		end else if (flush && (exp_q.size() != 0)) begin
			// flush drops the held packet
			void'(exp_q.pop_front());
			dropped++;
		end
		if (accept) begin
			exp_q.push_back(expected_packet(fetch));
			accepted++;
			if (fetch.instr[31:26] == `OP_HALT)
				model_halted = 1'b1;
		end
		held = dec_valid && !dec_ready && !flush;
		held_dec = dec;
		offer_pending = fetch_valid && !accept;
		// writes land after the operands are read since there is no bypass
		if (writeback.wen && (writeback.wsel != '0))
			shadow[writeback.wsel] = writeback.wdat;
	endtask

	task automatic wait_for_halt_accept();
		int n;
		n = 0;
		while (!model_halted && (n < timeout_cycles)) begin
			run_cycle();
			n++;
		end
		if (!model_halted) begin
			errors++;
			timed_out = 1'b1;
			$display("ERROR: timed out waiting for the HALT packet to be accepted");
		end
	endtask

	task automatic wait_for_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0) && (n < timeout_cycles)) begin
			run_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			timed_out = 1'b1;
			$display("ERROR: timed out waiting for the output register to drain");
		end
	endtask

	initial begin
		seed = 36;
		nRST = 1'b0;
		fetch_valid = 1'b0;
		fetch = '0;
		dec_ready = 1'b0;
		writeback = '0;
		flush = 1'b0;
		for (int i = 0; i < `REG_N; i++)
			shadow[i] = '0;
		held = 1'b0;
		model_halted = 1'b0;
		offer_pending = 1'b0;
		flush_enable = 1'b0;
		want_halt = 1'b0;
		halt_sent = 1'b0;
		halt_left = 1'b0;
		timed_out = 1'b0;
		errors = 0;
		checks = 0;
		accepted = 0;
		delivered = 0;
		dropped = 0;
		pc = rand_word() & 32'hffff_fffc;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		// mixed traffic with back-pressure, writebacks and flushes
		flush_enable = 1'b1;
		repeat (random_cycles) run_cycle();
		// halt near the end without flushes so it reaches the output
		flush_enable = 1'b0;
		want_halt = 1'b1;
		wait_for_halt_accept();
		if (!timed_out) begin
			repeat (100) begin
				run_cycle();
				if (!halted) begin
					errors++;
					$display("FAILED halted: got %h expected %h after HALT", halted, 1'b1);
				end
				if (fetch_ready) begin
					errors++;
					$display("FAILED fetch_ready: got %h expected %h after HALT",
						fetch_ready, 1'b0);
				end
			end
			wait_for_drain();
		end
		if (!timed_out && (accepted != delivered + dropped)) begin
			errors++;
			$display("ERROR: packets lost or duplicated between input and output");
		end
		if (!halt_left) begin
			errors++;
			$display("ERROR: the HALT packet never left the stage");
		end
		$display("errors %0d, checks %0d, accepted %0d, delivered %0d, flushed %0d",
			errors, checks, accepted, delivered, dropped);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
logic/cpu_types_pkg.sv
logic/pipe_types_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/decode_top.sv
test/decode_tb.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := decode_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
